// File: common/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Width of one data word in bits.
`define DC_DATA_W 32

// One select bit per byte of the data word.
`define DC_SEL_W 4

// Word address width on both PI1 ports.
`define DC_ADDR_W 14

// Number of direct-mapped sets.
// It must equal two to the power of DC_IDX_W.
`define DC_SETS 16

// Set index width, taken from the low bits of the word address.
`define DC_IDX_W 4

// Number of writes the write buffer can hold before the cache
// stops accepting operations.
`define DC_WBUF_DEPTH 4

`endif

// File: common/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

	// PI1 bus operations. Code 2'b11 (read-write) is never issued by this cache.
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10
	} pi1_op_e;

	// Controller states, from the reset sweep through the miss fill.
	typedef enum logic [2:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_LOOKUP,
		ST_DRAIN,
		ST_FILL_REQ,
		ST_FILL_WAIT
	} ctrl_state_e;

	typedef logic [`DC_ADDR_W-1:0] addr_t;
	typedef logic [`DC_DATA_W-1:0] data_t;
	typedef logic [`DC_SEL_W-1:0]  sel_t;
	typedef logic [`DC_IDX_W-1:0]  idx_t;

	// The address bits above the set index form the tag.
	typedef logic [`DC_ADDR_W-`DC_IDX_W-1:0] tag_t;

endpackage

// File: source/write_buffer.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module write_buffer import dcache_pkg::*; #(
	parameter int depth = `DC_WBUF_DEPTH
) (
	input  logic  clk_i,
	input  logic  rst_i,
	input  logic  push_i,
	input  addr_t addr_i,
	input  data_t data_i,
	input  sel_t  sel_i,
	input  logic  pop_i,
	output addr_t head_addr_o,
	output data_t head_data_o,
	output sel_t  head_sel_o,
	output logic  empty_o,
	output logic  full_o
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	addr_t addr_mem [depth];
	data_t data_mem [depth];
	sel_t  sel_mem  [depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	logic do_push;
	logic do_pop;

	// Requests against a full or empty buffer are ignored.
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign empty_o = (count == '0);
	assign full_o  = (count == cnt_w'(depth));

	// The oldest entry is always presented, so the drain needs no read cycle.
	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];
	assign head_sel_o  = sel_mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= addr_i;
			data_mem[wr_ptr] <= data_i;
			sel_mem[wr_ptr]  <= sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: dcache/dcache_array.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_array import dcache_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_i,
	input  logic  crst_i,
	input  addr_t hold_addr_i,
	input  sel_t  hold_sel_i,
	input  data_t hold_data_i,
	input  data_t fill_data_i,
	input  logic  fill_i,
	input  logic  line_we_i,
	output logic  hit_o,
	output data_t line_data_o,
	output logic  sweep_busy_o
);

	// Per-set storage. Only the valid bits are cleared by the sweep.
	tag_t  tag_mem  [`DC_SETS];
	sel_t  mask_mem [`DC_SETS];
	data_t data_mem [`DC_SETS];
	logic [`DC_SETS-1:0] valid;

	idx_t line_idx;
	tag_t line_tag;
	logic tag_match;

	data_t src_data;
	data_t merge_data;
	sel_t  merge_mask;

	logic sweep_busy;
	idx_t sweep_idx;

	assign line_idx = hold_addr_i[`DC_IDX_W-1:0];
	assign line_tag = hold_addr_i[`DC_ADDR_W-1:`DC_IDX_W];

	// The lookup is purely combinational on the held request.
	assign tag_match   = valid[line_idx] && (tag_mem[line_idx] == line_tag);
	assign hit_o       = tag_match && ((mask_mem[line_idx] & hold_sel_i) == hold_sel_i);
	assign line_data_o = data_mem[line_idx];

	// A fill merges the memory read data, a write merges the held write data.
	assign src_data = fill_i ? fill_data_i : hold_data_i;

	always_comb begin
		merge_data = data_mem[line_idx];
		for (int b = 0; b < `DC_SEL_W; b++) begin
			if (hold_sel_i[b])
				merge_data[b*8 +: 8] = src_data[b*8 +: 8];
		end
	end

	// Bytes already held for the same tag stay valid.
	// A new tag starts its mask over from the current selects.
	assign merge_mask = tag_match ? (mask_mem[line_idx] | hold_sel_i) : hold_sel_i;

	always_ff @(posedge clk_i) begin
		if (line_we_i) begin
			tag_mem[line_idx]  <= line_tag;
			mask_mem[line_idx] <= merge_mask;
			data_mem[line_idx] <= merge_data;
		end
	end

	// The sweep walks every set once, one set per cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i || crst_i) begin
			sweep_busy <= 1'b1;
			sweep_idx  <= '0;
		end else if (sweep_busy) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == idx_t'(`DC_SETS - 1))
				sweep_busy <= 1'b0;
		end
	end

	// A line write lands after the sweep clear, so it wins on the same set.
	always_ff @(posedge clk_i) begin
		if (sweep_busy)
			valid[sweep_idx] <= 1'b0;
		if (line_we_i)
			valid[line_idx] <= 1'b1;
	end

	assign sweep_busy_o = sweep_busy;

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    crst_i,
	input  pi1_op_e m_op_i,
	input  addr_t   m_addr_i,
	input  data_t   m_data_i,
	input  sel_t    m_sel_i,
	output data_t   m_data_o,
	output logic    m_rdy_o,
	output pi1_op_e s_op_o,
	output addr_t   s_addr_o,
	output data_t   s_data_o,
	output sel_t    s_sel_o,
	input  data_t   s_data_i,
	input  logic    s_rdy_i,
	output logic    wb_push_o,
	output logic    wb_pop_o,
	input  addr_t   wb_head_addr_i,
	input  data_t   wb_head_data_i,
	input  sel_t    wb_head_sel_i,
	input  logic    wb_empty_i,
	input  logic    wb_full_i,
	output addr_t   hold_addr_o,
	output sel_t    hold_sel_o,
	output data_t   hold_data_o,
	output data_t   fill_data_o,
	output logic    fill_o,
	output logic    line_we_o,
	input  logic    hit_i,
	input  data_t   line_data_i,
	input  logic    sweep_busy_i
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	// The accepted request is held until the next one is accepted.
	pi1_op_e hold_op;
	addr_t   hold_addr;
	sel_t    hold_sel;
	data_t   hold_data;

	logic can_accept;
	logic drain_en;
	logic fill_req;

	// A read can only complete once its bytes are in the line.
	always_comb begin
		case (state)
			ST_SWEEP:  can_accept = 1'b1;
			ST_IDLE:   can_accept = 1'b1;
			ST_LOOKUP: can_accept = (hold_op == PI1_WR) || hit_i;
			default:   can_accept = 1'b0;
		endcase
	end

	// Any accepted op may be a write, so a full buffer stalls everything.
	assign m_rdy_o  = can_accept && !wb_full_i && !sweep_busy_i && !crst_i;
	assign m_data_o = line_data_i;

	assign wb_push_o = m_rdy_o && (m_op_i == PI1_WR);

	// Buffered writes drain in the background, except around a fill.
	// The fill is only requested once the buffer is empty, so memory
	// always sees the writes before the read.
	assign fill_req = (state == ST_FILL_REQ);
	assign drain_en = !wb_empty_i && (state != ST_FILL_REQ) && (state != ST_FILL_WAIT);
	assign wb_pop_o = drain_en && s_rdy_i;

	assign s_op_o   = fill_req ? PI1_RD : (drain_en ? PI1_WR : PI1_NOP);
	assign s_addr_o = fill_req ? hold_addr : wb_head_addr_i;
	assign s_sel_o  = fill_req ? hold_sel : wb_head_sel_i;
	assign s_data_o = wb_head_data_i;

	assign hold_addr_o = hold_addr;
	assign hold_sel_o  = hold_sel;
	assign hold_data_o = hold_data;
	assign fill_data_o = s_data_i;
	assign fill_o      = (state == ST_FILL_WAIT);

	// Writes update the line in their lookup cycle, fills when read data arrives.
	assign line_we_o = ((state == ST_LOOKUP) && (hold_op == PI1_WR)) ||
		((state == ST_FILL_WAIT) && s_rdy_i);

	always_comb begin
		state_nxt = state;
		if (m_rdy_o) begin
			state_nxt = (m_op_i != PI1_NOP) ? ST_LOOKUP : ST_IDLE;
		end else begin
			case (state)
				ST_LOOKUP: begin
					// A hit stalled by a full buffer keeps its data on the line.
					if (hold_op == PI1_WR)
						state_nxt = ST_IDLE;
					else if (!hit_i)
						state_nxt = wb_empty_i ? ST_FILL_REQ : ST_DRAIN;
				end
				ST_DRAIN: begin
					if (wb_empty_i)
						state_nxt = ST_FILL_REQ;
				end
				ST_FILL_REQ: begin
					if (s_rdy_i)
						state_nxt = ST_FILL_WAIT;
				end
				ST_FILL_WAIT: begin
					// Back to lookup, which now hits on the filled line.
					if (s_rdy_i)
						state_nxt = ST_LOOKUP;
				end
				default: state_nxt = state;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state   <= ST_SWEEP;
			hold_op <= PI1_NOP;
		end else begin
			state <= state_nxt;
			if (m_rdy_o)
				hold_op <= m_op_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (m_rdy_o) begin
			hold_addr <= m_addr_i;
			hold_sel  <= m_sel_i;
			hold_data <= m_data_i;
		end
	end

endmodule

// File: dcache/pi1_dcache.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module pi1_dcache import dcache_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    crst_i,
	input  pi1_op_e m_op_i,
	input  addr_t   m_addr_i,
	input  data_t   m_data_i,
	input  sel_t    m_sel_i,
	output data_t   m_data_o,
	output logic    m_rdy_o,
	output pi1_op_e s_op_o,
	output addr_t   s_addr_o,
	output data_t   s_data_o,
	output sel_t    s_sel_o,
	input  data_t   s_data_i,
	input  logic    s_rdy_i
);

	logic  wb_push;
	logic  wb_pop;
	addr_t wb_head_addr;
	data_t wb_head_data;
	sel_t  wb_head_sel;
	logic  wb_empty;
	logic  wb_full;

	addr_t hold_addr;
	sel_t  hold_sel;
	data_t hold_data;
	data_t fill_data;
	logic  fill;
	logic  line_we;
	logic  hit;
	data_t line_data;
	logic  sweep_busy;

	dcache_ctrl i_dcache_ctrl (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.crst_i         (crst_i),
		.m_op_i         (m_op_i),
		.m_addr_i       (m_addr_i),
		.m_data_i       (m_data_i),
		.m_sel_i        (m_sel_i),
		.m_data_o       (m_data_o),
		.m_rdy_o        (m_rdy_o),
		.s_op_o         (s_op_o),
		.s_addr_o       (s_addr_o),
		.s_data_o       (s_data_o),
		.s_sel_o        (s_sel_o),
		.s_data_i       (s_data_i),
		.s_rdy_i        (s_rdy_i),
		.wb_push_o      (wb_push),
		.wb_pop_o       (wb_pop),
		.wb_head_addr_i (wb_head_addr),
		.wb_head_data_i (wb_head_data),
		.wb_head_sel_i  (wb_head_sel),
		.wb_empty_i     (wb_empty),
		.wb_full_i      (wb_full),
		.hold_addr_o    (hold_addr),
		.hold_sel_o     (hold_sel),
		.hold_data_o    (hold_data),
		.fill_data_o    (fill_data),
		.fill_o         (fill),
		.line_we_o      (line_we),
		.hit_i          (hit),
		.line_data_i    (line_data),
		.sweep_busy_i   (sweep_busy)
	);

	dcache_array i_dcache_array (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.crst_i       (crst_i),
		.hold_addr_i  (hold_addr),
		.hold_sel_i   (hold_sel),
		.hold_data_i  (hold_data),
		.fill_data_i  (fill_data),
		.fill_i       (fill),
		.line_we_i    (line_we),
		.hit_o        (hit),
		.line_data_o  (line_data),
		.sweep_busy_o (sweep_busy)
	);

	// Writes enter the buffer straight from the processor port on acceptance.
	write_buffer #(
		.depth (`DC_WBUF_DEPTH)
	) i_write_buffer (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (wb_push),
		.addr_i      (m_addr_i),
		.data_i      (m_data_i),
		.sel_i       (m_sel_i),
		.pop_i       (wb_pop),
		.head_addr_o (wb_head_addr),
		.head_data_o (wb_head_data),
		.head_sel_o  (wb_head_sel),
		.empty_o     (wb_empty),
		.full_o      (wb_full)
	);

endmodule

// File: bench/pi1_dcache_assert.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module pi1_dcache_assert import dcache_pkg::*; (
	input logic    clk_i,
	input logic    rst_i,
	input pi1_op_e s_op_o,
	input addr_t   s_addr_o,
	input data_t   s_data_o,
	input sel_t    s_sel_o,
	input logic    s_rdy_i,
	input logic    wb_empty_i,
	input logic    m_rdy_o
);

	// A stalled memory request stays exactly as it was.
	bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		((s_op_o != PI1_NOP) && !s_rdy_i) |=>
		($stable(s_op_o) && $stable(s_addr_o) && $stable(s_data_o) && $stable(s_sel_o)))
		else $error("Memory bus request changed while the memory stalled.");

	// Fills go out only after every buffered write.
	read_after_drain: assert property (@(posedge clk_i) disable iff (rst_i)
		(s_op_o == PI1_RD) |-> wb_empty_i)
		else $error("Memory read issued while the write buffer held entries.");

	// The sweep clears one set per cycle after reset.
	// The processor port stays closed through the last set and opens right after it.
	sweep_not_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(rst_i) |-> !m_rdy_o ##(`DC_SETS - 1) !m_rdy_o ##1 m_rdy_o)
		else $error("Processor port ready state wrong around the end of the reset sweep.");

endmodule

// File: bench/pi1_dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module pi1_dcache_tb import dcache_pkg::*; ();

	localparam int NUM_ROWS        = 28;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;

	// One processor operation together with what it must produce.
	typedef struct packed {
		logic    crst;
		pi1_op_e op;
		addr_t   addr;
		data_t   data;
		sel_t    sel;
		data_t   exp;
		logic    bus_rd;
	} row_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
		sel_t  sel;
	} wr_entry_t;

	logic    clk_i;
	logic    rst_i;
	logic    crst_i;
	pi1_op_e m_op_i;
	addr_t   m_addr_i;
	data_t   m_data_i;
	sel_t    m_sel_i;
	data_t   m_data_o;
	logic    m_rdy_o;
	pi1_op_e s_op_o;
	addr_t   s_addr_o;
	data_t   s_data_o;
	sel_t    s_sel_o;
	data_t   s_data_i;
	logic    s_rdy_i;

	data_t     mem [1 << `DC_ADDR_W];
	wr_entry_t exp_wr [$];
	addr_t     rd_addr_exp;
	sel_t      rd_sel_exp;
	int        bus_reads = 0;

	// Each row holds crst, op, address, write data, select, expected read data and bus read.
	// Untouched memory words read as {2'b10, addr, 2'b01, addr}.
	row_t rows [NUM_ROWS] = '{
		'{1'b0, PI1_RD, 14'h0010, 32'h0000_0000, 4'b1111, 32'h8010_4010, 1'b1},
		'{1'b0, PI1_RD, 14'h0010, 32'h0000_0000, 4'b1111, 32'h8010_4010, 1'b0},
		'{1'b0, PI1_WR, 14'h0021, 32'h1234_5678, 4'b0011, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_RD, 14'h0021, 32'h0000_0000, 4'b0011, 32'h0000_5678, 1'b0},
		'{1'b0, PI1_RD, 14'h0021, 32'h0000_0000, 4'b1100, 32'h8021_0000, 1'b1},
		'{1'b0, PI1_RD, 14'h0021, 32'h0000_0000, 4'b1111, 32'h8021_5678, 1'b0},
		'{1'b0, PI1_WR, 14'h0030, 32'hCAFE_F00D, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_RD, 14'h0010, 32'h0000_0000, 4'b1111, 32'h8010_4010, 1'b1},
		'{1'b0, PI1_RD, 14'h0030, 32'h0000_0000, 4'b1111, 32'hCAFE_F00D, 1'b1},
		'{1'b0, PI1_WR, 14'h0102, 32'h1111_1111, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0112, 32'h2222_2222, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0207, 32'h0000_00AB, 4'b0001, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_RD, 14'h0102, 32'h0000_0000, 4'b1111, 32'h1111_1111, 1'b1},
		'{1'b0, PI1_RD, 14'h0207, 32'h0000_0000, 4'b1111, 32'h8207_42AB, 1'b1},
		'{1'b0, PI1_RD, 14'h0112, 32'h0000_0000, 4'b1111, 32'h2222_2222, 1'b1},
		'{1'b0, PI1_RD, 14'h0207, 32'h0000_0000, 4'b1111, 32'h8207_42AB, 1'b0},
		'{1'b1, PI1_RD, 14'h0207, 32'h0000_0000, 4'b1111, 32'h8207_42AB, 1'b1},
		'{1'b0, PI1_RD, 14'h0207, 32'h0000_0000, 4'b1111, 32'h8207_42AB, 1'b0},
		'{1'b0, PI1_WR, 14'h0A00, 32'hA000_0001, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0A01, 32'hA100_0002, 4'b1100, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0A02, 32'hA200_0003, 4'b0110, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0A03, 32'hA300_0004, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0A04, 32'hA400_0005, 4'b1001, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_WR, 14'h0A05, 32'hA500_0006, 4'b1111, 32'h0000_0000, 1'b0},
		'{1'b0, PI1_RD, 14'h0A03, 32'h0000_0000, 4'b1111, 32'hA300_0004, 1'b0},
		'{1'b0, PI1_RD, 14'h0A01, 32'h0000_0000, 4'b0011, 32'h0000_4A01, 1'b1},
		'{1'b0, PI1_RD, 14'h0A01, 32'h0000_0000, 4'b1111, 32'hA100_4A01, 1'b0},
		'{1'b0, PI1_RD, 14'h0A04, 32'h0000_0000, 4'b1001, 32'hA400_0005, 1'b0}
	};

	pi1_dcache i_pi1_dcache (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.crst_i   (crst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o),
		.s_data_i (s_data_i),
		.s_rdy_i  (s_rdy_i)
	);

	bind dcache_ctrl pi1_dcache_assert i_pi1_dcache_assert (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic data_t init_word(input addr_t a);
		return {2'b10, a, 2'b01, a};
	endfunction

	task automatic report_failure(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first failed check.");
	endtask

	// Only the selected bytes are defined, so the rest is masked off.
	task automatic check_data(input data_t got, input data_t exp, input sel_t sel,
		input string what);
		data_t mask;
		for (int b = 0; b < `DC_SEL_W; b++)
			mask[b*8 +: 8] = {8{sel[b]}};
		if ((got & mask) !== (exp & mask))
			report_failure($sformatf("%s: got %h, expected %h (sel %b)", what, got, exp, sel));
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_sel(input sel_t got, input sel_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	task automatic check_op(input pi1_op_e got, input pi1_op_e exp, input string what);
		if (got !== exp)
			report_failure($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_failure($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	// Called a little after a falling edge. Returns once m_rdy_o is high,
	// which then holds until the next rising edge.
	task automatic wait_ready();
		#1;
		while (!m_rdy_o) begin
			@(negedge clk_i);
			#1;
		end
	endtask

	// A memory operation issues on the coming rising edge.
	// Writes must arrive in acceptance order, and a read only once they are all out.
	task automatic serve_bus();
		wr_entry_t e;
		pi1_op_e   exp_op;
		if (exp_wr.size() != 0)
			exp_op = PI1_WR;
		else
			exp_op = PI1_RD;
		check_op(s_op_o, exp_op, "memory bus operation");
		if (s_op_o == PI1_WR) begin
			e = exp_wr.pop_front();
			check_addr(s_addr_o, e.addr, "bus write address");
			check_sel(s_sel_o, e.sel, "bus write select");
			check_data(s_data_o, e.data, e.sel, "bus write data");
			for (int b = 0; b < `DC_SEL_W; b++) begin
				if (s_sel_o[b])
					mem[s_addr_o][b*8 +: 8] = s_data_o[b*8 +: 8];
			end
		end else begin
			check_addr(s_addr_o, rd_addr_exp, "bus read address");
			check_sel(s_sel_o, rd_sel_exp, "bus read select");
			s_data_i = mem[s_addr_o];
			bus_reads++;
		end
	endtask

	// Starts and ends on a falling edge.
	task automatic apply_row(input row_t r);
		int        reads_before;
		wr_entry_t e;
		reads_before = bus_reads;
		if (r.crst) begin
			crst_i = 1'b1;
			@(negedge clk_i);
			crst_i = 1'b0;
		end
		m_op_i   = r.op;
		m_addr_i = r.addr;
		m_data_i = r.data;
		m_sel_i  = r.sel;
		if (r.op == PI1_RD) begin
			rd_addr_exp = r.addr;
			rd_sel_exp  = r.sel;
		end
		wait_ready();
		if (r.op == PI1_WR) begin
			e.addr = r.addr;
			e.data = r.data;
			e.sel  = r.sel;
			exp_wr.push_back(e);
		end
		@(negedge clk_i);
		m_op_i = PI1_NOP;
		if (r.op == PI1_RD) begin
			wait_ready();
			check_data(m_data_o, r.exp, r.sel, "read data");
			@(negedge clk_i);
		end
		check_count(bus_reads - reads_before, int'(r.bus_rd), "bus reads for this row");
	endtask

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// Memory model with random stalls.
	initial begin
		logic [31:0] rnd;
		rnd      = 32'd59048;
		s_rdy_i  = 1'b1;
		s_data_i = '0;
		for (int a = 0; a < (1 << `DC_ADDR_W); a++)
			mem[a] = init_word(addr_t'(a));
		forever begin
			@(negedge clk_i);
			rnd     = xorshift32(rnd);
			s_rdy_i = rst_i || (rnd[1:0] != 2'b00);
			if (!rst_i && s_rdy_i && (s_op_o != PI1_NOP))
				serve_bus();
		end
	end

	initial begin
		rst_i    = 1'b1;
		crst_i   = 1'b0;
		m_op_i   = PI1_NOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i  = '0;
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(rows[i]);
		while (exp_wr.size() != 0)
			@(negedge clk_i);
		@(negedge clk_i);
		check_op(s_op_o, PI1_NOP, "memory bus after the last write");
		$display(">>> PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Watchdog expired after %0d cycles before the test finished.", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$fatal(1, "The DUT stopped making progress.");
	end

endmodule

// File: flist.f
+incdir+common
common/dcache_pkg.sv
source/write_buffer.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
dcache/pi1_dcache.sv
bench/pi1_dcache_assert.sv
bench/pi1_dcache_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the simulation fails.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	--top-module pi1_dcache_tb \
	-f flist.f \
	-o pi1_dcache_sim &&
./obj_dir/pi1_dcache_sim || exit 1
